//--- tests/write_cases.txt
// Columns, all hex: byte offset, byte count, back-pressure level 0 (none) to 3 (heavy)
// A line with a zero count ends the list
00000000 00000001 0
00001004 00000004 1
10000123 00000005 2
00002000 000003ff 0
000033fc 00000400 1
00004001 00000401 2
7fff0abc 00000bb9 3
00010000 00000bb9 0
00020010 00000002 3
00030000 00000003 1
00040000 00010000 0
00050f00 00000800 2
00060000 00000801 3
00070000 00000000 0

//--- sources.f
rtl/axi_wr_pkg.sv
rtl/updown_counter.sv
rtl/wr_ctrl_fsm.sv
rtl/stream_fifo.sv
rtl/wdata_channel.sv
rtl/awaddr_channel.sv
rtl/axi_write_master.sv
tests/axi_write_master_props.sv
tests/wr_checker.sv
tests/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_top \
  -f sources.f --Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "sim failed" sim.log; then
  exit 1
fi
if ! grep -q "sim passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

//--- tests/tb_top.sv
`timescale 1ns/1ns

module tb_top;
  import axi_wr_pkg::*;

  localparam int MAX_CASES  = 32;
  localparam int WAIT_LIMIT = 200000;

  logic       aclk;
  logic       areset;
  logic       ctrl_start;
  addr_t      ctrl_addr_offset;
  xfer_size_t ctrl_xfer_size;
  logic       ctrl_busy;
  logic       ctrl_done;
  logic       m_axi_awvalid;
  logic       m_axi_awready;
  addr_t      m_axi_awaddr;
  beat_len_t  m_axi_awlen;
  logic       m_axi_wvalid;
  logic       m_axi_wready;
  data_t      m_axi_wdata;
  strb_t      m_axi_wstrb;
  logic       m_axi_wlast;
  logic       m_axi_bvalid;
  logic       m_axi_bready;
  logic       s_axis_tvalid;
  logic       s_axis_tready;
  data_t      s_axis_tdata;

  logic [31:0] case_mem [0:3*MAX_CASES-1];
  int          bp_level;
  int          tb_errors;
  data_t       next_word;
  bit          timed_out;
  // Slave model progress
  int          aw_seen;
  int          wlast_seen;
  int          b_seen;

  axi_write_master dut0 (.*);

  wr_checker u_chk (.*);

  bind axi_write_master axi_write_master_props u_props (.*);

  initial begin
    aclk = 1'b0;
    forever #10 aclk = ~aclk;
  end

  // Ready or valid for one cycle, scarcer at higher levels
  function automatic logic ready_draw(int level);
    return int'($urandom % 4) >= level;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // AXI slave model
  //////////////////////////////////////////////////////////////////////

  always @(posedge aclk) begin : slave_model
    int done_bursts;
    if (areset) begin
      m_axi_awready <= 1'b0;
      m_axi_wready  <= 1'b0;
      m_axi_bvalid  <= 1'b0;
      aw_seen    = 0;
      wlast_seen = 0;
      b_seen     = 0;
    end else begin
      aw_seen    += int'(m_axi_awvalid && m_axi_awready);
      wlast_seen += int'(m_axi_wvalid && m_axi_wready && m_axi_wlast);
      // A burst is complete once both its address and its wlast are in
      done_bursts = (aw_seen < wlast_seen) ? aw_seen : wlast_seen;
      if (m_axi_bvalid) begin
        if (b_seen >= done_bursts) begin
          $display("Error: write response given before its burst was complete");
          tb_errors++;
        end
        b_seen++;
      end
      m_axi_awready <= ready_draw(bp_level);
      m_axi_wready  <= ready_draw(bp_level);
      // Responses wait while W is busy, so long transfers reach the credit limit
      m_axi_bvalid  <= !m_axi_bvalid && !m_axi_wvalid && (b_seen < done_bursts) &&
                       ($urandom % 4 == 0);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stream source and control
  //////////////////////////////////////////////////////////////////////

  task automatic stream_beats(int beats);
    int sent;
    int t;
    sent = 0;
    t    = 0;
    while (sent < beats && t < WAIT_LIMIT) begin
      @(posedge aclk);
      t++;
      if (s_axis_tvalid && s_axis_tready) begin
        sent++;
        next_word++;
      end
      // A word on offer stays until taken
      if (!s_axis_tvalid || s_axis_tready) begin
        if (sent < beats && ready_draw(bp_level)) begin
          s_axis_tvalid <= 1'b1;
          s_axis_tdata  <= next_word;
        end else begin
          s_axis_tvalid <= 1'b0;
        end
      end
    end
    s_axis_tvalid <= 1'b0;
    if (sent < beats) begin
      $display("Error: timed out streaming beat %0d of %0d", sent, beats);
      tb_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_done();
    int t;
    t = 0;
    while (!ctrl_done && t < WAIT_LIMIT) begin
      @(posedge aclk);
      t++;
      // Extra start in mid transfer
      ctrl_start <= (t == 3) && ctrl_busy;
    end
    ctrl_start <= 1'b0;
    if (!ctrl_done) begin
      $display("Error: timed out waiting for ctrl_done");
      tb_errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic run_case(logic [31:0] offset, logic [31:0] size, logic [31:0] level);
    bp_level = int'(level);
    @(posedge aclk);
    ctrl_start       <= 1'b1;
    ctrl_addr_offset <= offset;
    ctrl_xfer_size   <= xfer_size_t'(size);
    @(posedge aclk);
    ctrl_start <= 1'b0;
    fork
      stream_beats((int'(size) + 3) / 4);
      wait_done();
    join
  endtask

  initial begin
    int n;
    void'($urandom(32'h2a04));
    areset           = 1'b1;
    ctrl_start       = 1'b0;
    ctrl_addr_offset = '0;
    ctrl_xfer_size   = '0;
    s_axis_tvalid    = 1'b0;
    s_axis_tdata     = '0;
    m_axi_awready    = 1'b0;
    m_axi_wready     = 1'b0;
    m_axi_bvalid     = 1'b0;
    bp_level         = 0;
    tb_errors        = 0;
    next_word        = '0;
    timed_out        = 1'b0;
    $readmemh("tests/write_cases.txt", case_mem);
    repeat (3) @(posedge aclk);
    areset <= 1'b0;
    @(posedge aclk);
    n = 0;
    while (n < MAX_CASES && !timed_out && case_mem[3*n+1] != 0) begin
      run_case(case_mem[3*n], case_mem[3*n+1], case_mem[3*n+2]);
      n++;
    end
    repeat (5) @(posedge aclk);
    $display("errors: checker %0d, testbench %0d, cases %0d", u_chk.err_count, tb_errors, n);
    if (u_chk.err_count == 0 && tb_errors == 0 && n > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- tests/wr_checker.sv
`timescale 1ns/1ns

module wr_checker (
  input logic                  aclk,
  input logic                  areset,
  input logic                  ctrl_start,
  input logic                  ctrl_busy,
  input logic                  ctrl_done,
  input logic                  m_axi_awvalid,
  input logic                  m_axi_awready,
  input axi_wr_pkg::addr_t     m_axi_awaddr,
  input axi_wr_pkg::beat_len_t m_axi_awlen,
  input logic                  m_axi_wvalid,
  input logic                  m_axi_wready,
  input axi_wr_pkg::data_t     m_axi_wdata,
  input axi_wr_pkg::strb_t     m_axi_wstrb,
  input logic                  m_axi_wlast,
  input logic                  m_axi_bvalid,
  input logic                  m_axi_bready,
  input logic                  s_axis_tready
);
  import axi_wr_pkg::*;

  localparam int MAX_CASES = 32;

  logic [31:0] case_mem [0:3*MAX_CASES-1];
  int          err_count;
  int          case_idx;
  // Prediction for the current case
  int          exp_beats;
  int          exp_bursts;
  addr_t       exp_base;
  strb_t       exp_strb;
  // Progress through the current case
  int          aw_i;
  int          w_burst;
  int          w_beat;
  int          w_total;
  int          b_i;
  data_t       exp_word;
  logic        expect_done;
  logic        in_xfer;
  logic        seen_reset;

  task automatic value_error(string name, logic [31:0] got, logic [31:0] exp);
    $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
    err_count++;
  endtask

  task automatic note_error(string msg);
    $display("Error: %s", msg);
    err_count++;
  endtask

  task automatic predict_case(int idx);
    int size;
    int rem;
    size       = int'(case_mem[3*idx+1]);
    rem        = size % 4;
    exp_beats  = (size + 3) / 4;
    exp_bursts = (exp_beats + 255) / 256;
    exp_base   = case_mem[3*idx] & 32'hffff_fc00;
    // Low bytes of the tail beat only
    exp_strb   = (rem == 0) ? 4'hf : strb_t'((1 << rem) - 1);
    aw_i       = 0;
    w_burst    = 0;
    w_beat     = 0;
    w_total    = 0;
    b_i        = 0;
  endtask

  // Beats in burst k, only the last one is short
  function automatic int burst_len(int k);
    return (k == exp_bursts - 1) ? exp_beats - 256 * k : 256;
  endfunction

  initial begin
    $readmemh("tests/write_cases.txt", case_mem);
    err_count   = 0;
    case_idx    = 0;
    exp_word    = '0;
    expect_done = 1'b0;
    in_xfer     = 1'b0;
    seen_reset  = 1'b0;
    predict_case(0);
  end

  //////////////////////////////////////////////////////////////////////
  // Port monitor
  //////////////////////////////////////////////////////////////////////

  always @(posedge aclk) begin
    if (areset) begin
      // Outputs have seen at least one reset edge
      if (seen_reset) begin
        if (m_axi_awvalid !== 1'b0) value_error("m_axi_awvalid", m_axi_awvalid, 0);
        if (m_axi_wvalid !== 1'b0) value_error("m_axi_wvalid", m_axi_wvalid, 0);
        if (ctrl_done !== 1'b0) value_error("ctrl_done", ctrl_done, 0);
        if (ctrl_busy !== 1'b0) value_error("ctrl_busy", ctrl_busy, 0);
        if (s_axis_tready !== 1'b1) value_error("s_axis_tready", s_axis_tready, 1);
      end
      seen_reset  = 1'b1;
      expect_done = 1'b0;
      in_xfer     = 1'b0;
    end else begin
      if (ctrl_busy !== in_xfer) value_error("ctrl_busy", ctrl_busy, in_xfer);
      if (ctrl_done !== expect_done) value_error("ctrl_done", ctrl_done, expect_done);
      // Responses are always taken
      if (m_axi_bready !== 1'b1) value_error("m_axi_bready", m_axi_bready, 1);
      expect_done = 1'b0;
      // Start while busy is ignored
      if (ctrl_start && !ctrl_busy) in_xfer = 1'b1;

      if (m_axi_awvalid && m_axi_awready) begin
        if (aw_i >= exp_bursts) begin
          note_error("burst address issued beyond the end of the transfer");
        end else begin
          if (m_axi_awaddr !== exp_base + addr_t'(1024 * aw_i))
            value_error("m_axi_awaddr", m_axi_awaddr, exp_base + addr_t'(1024 * aw_i));
          if (m_axi_awlen !== beat_len_t'(burst_len(aw_i) - 1))
            value_error("m_axi_awlen", m_axi_awlen, burst_len(aw_i) - 1);
        end
        aw_i++;
      end

      if (m_axi_wvalid && m_axi_wready) begin
        if (w_total >= exp_beats) begin
          note_error("data beat sent beyond the end of the transfer");
        end else begin
          if (m_axi_wdata !== exp_word) value_error("m_axi_wdata", m_axi_wdata, exp_word);
          if (m_axi_wlast !== (w_beat == burst_len(w_burst) - 1))
            value_error("m_axi_wlast", m_axi_wlast, w_beat == burst_len(w_burst) - 1);
          if (w_total == exp_beats - 1) begin
            if (m_axi_wstrb !== exp_strb) value_error("m_axi_wstrb", m_axi_wstrb, exp_strb);
          end else if (m_axi_wstrb !== 4'hf) begin
            value_error("m_axi_wstrb", m_axi_wstrb, 4'hf);
          end
        end
        w_total++;
        exp_word++;
        if (w_beat >= burst_len(w_burst) - 1) begin
          w_burst++;
          w_beat = 0;
        end else begin
          w_beat++;
        end
      end

      // bready is tied high, so bvalid alone is a response
      if (m_axi_bvalid) begin
        b_i++;
        if (b_i == exp_bursts) begin
          expect_done = 1'b1;
          in_xfer     = 1'b0;
        end else if (b_i > exp_bursts) begin
          note_error("write response beyond the bursts of the transfer");
        end
      end

      // Case closes, totals must match the prediction
      if (ctrl_done) begin
        if (aw_i != exp_bursts) value_error("burst count", aw_i, exp_bursts);
        if (w_total != exp_beats) value_error("beat count", w_total, exp_beats);
        if (b_i != exp_bursts) value_error("response count", b_i, exp_bursts);
        case_idx++;
        if (case_idx < MAX_CASES) predict_case(case_idx);
      end
    end
  end

endmodule

//--- tests/axi_write_master_props.sv
`timescale 1ns/1ns

module axi_write_master_props (
  input logic                  aclk,
  input logic                  areset,
  input logic                  m_axi_awvalid,
  input logic                  m_axi_awready,
  input axi_wr_pkg::addr_t     m_axi_awaddr,
  input axi_wr_pkg::beat_len_t m_axi_awlen,
  input logic                  m_axi_wvalid,
  input logic                  m_axi_wready,
  input axi_wr_pkg::data_t     m_axi_wdata,
  input axi_wr_pkg::strb_t     m_axi_wstrb,
  input logic                  m_axi_wlast,
  input logic                  m_axi_bvalid,
  input logic                  m_axi_bready
);

  // Bursts addressed but not yet answered
  int outstanding;

  always_ff @(posedge aclk) begin
    if (areset) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(m_axi_awvalid && m_axi_awready)
                     - int'(m_axi_bvalid && m_axi_bready);
    end
  end

  // Stalled address holds valid and payload
  aw_stable: assert property (@(posedge aclk) disable iff (areset)
    m_axi_awvalid && !m_axi_awready |=>
      m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awlen))
    else $error("write address changed while stalled");

  // Stalled data beat holds valid and payload
  w_stable: assert property (@(posedge aclk) disable iff (areset)
    m_axi_wvalid && !m_axi_wready |=>
      m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wstrb) && $stable(m_axi_wlast))
    else $error("write data changed while stalled");

  credit_limit: assert property (@(posedge aclk) disable iff (areset) outstanding <= 32)
    else $error("more than 32 bursts wait for a response");

endmodule

//--- rtl/axi_write_master.sv
`timescale 1ns/1ns

module axi_write_master #(
  parameter int MAX_OUTSTANDING = 32,
  parameter int FIFO_DEPTH      = 32
) (
  input  logic                   aclk,
  input  logic                   areset,
  // Control
  input  logic                   ctrl_start,
  input  axi_wr_pkg::addr_t      ctrl_addr_offset,
  input  axi_wr_pkg::xfer_size_t ctrl_xfer_size,
  output logic                   ctrl_busy,
  output logic                   ctrl_done,
  // AXI4 write address
  output logic                   m_axi_awvalid,
  input  logic                   m_axi_awready,
  output axi_wr_pkg::addr_t      m_axi_awaddr,
  output axi_wr_pkg::beat_len_t  m_axi_awlen,
  // AXI4 write data
  output logic                   m_axi_wvalid,
  input  logic                   m_axi_wready,
  output axi_wr_pkg::data_t      m_axi_wdata,
  output axi_wr_pkg::strb_t      m_axi_wstrb,
  output logic                   m_axi_wlast,
  // AXI4 write response
  input  logic                   m_axi_bvalid,
  output logic                   m_axi_bready,
  // AXI4-Stream input
  input  logic                   s_axis_tvalid,
  output logic                   s_axis_tready,
  input  axi_wr_pkg::data_t      s_axis_tdata
);
  import axi_wr_pkg::*;

  // Burst plan from the FSM to both channels
  logic       start;
  addr_t      base_addr;
  burst_cnt_t num_bursts;
  beat_len_t  final_len;
  strb_t      final_strb;
  // First beat of a burst seen on W
  logic       burst_begin;

  // Responses are always accepted
  assign m_axi_bready = 1'b1;

  wr_ctrl_fsm u_ctrl (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size   (ctrl_xfer_size),
    .m_axi_bvalid     (m_axi_bvalid),
    .ctrl_busy        (ctrl_busy),
    .ctrl_done        (ctrl_done),
    .start            (start),
    .base_addr        (base_addr),
    .num_bursts       (num_bursts),
    .final_len        (final_len),
    .final_strb       (final_strb)
  );

  wdata_channel #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_wdata (
    .aclk          (aclk),
    .areset        (areset),
    .start         (start),
    .num_bursts    (num_bursts),
    .final_len     (final_len),
    .final_strb    (final_strb),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .s_axis_tdata  (s_axis_tdata),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wstrb   (m_axi_wstrb),
    .m_axi_wlast   (m_axi_wlast),
    .burst_begin   (burst_begin)
  );

  awaddr_channel #(
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_awaddr (
    .aclk          (aclk),
    .areset        (areset),
    .start         (start),
    .base_addr     (base_addr),
    .num_bursts    (num_bursts),
    .final_len     (final_len),
    .burst_begin   (burst_begin),
    .m_axi_bvalid  (m_axi_bvalid),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awlen   (m_axi_awlen),
    .m_axi_awready (m_axi_awready)
  );

endmodule

//--- rtl/awaddr_channel.sv
`timescale 1ns/1ns

module awaddr_channel #(
  parameter int MAX_OUTSTANDING = 32
) (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   start,
  input  axi_wr_pkg::addr_t      base_addr,
  input  axi_wr_pkg::burst_cnt_t num_bursts,
  input  axi_wr_pkg::beat_len_t  final_len,
  input  logic                   burst_begin,
  input  logic                   m_axi_bvalid,
  output logic                   m_axi_awvalid,
  output axi_wr_pkg::addr_t      m_axi_awaddr,
  output axi_wr_pkg::beat_len_t  m_axi_awlen,
  input  logic                   m_axi_awready
);
  import axi_wr_pkg::*;

  localparam int CREDIT_W = $clog2(MAX_OUTSTANDING + 1);
  // W may run ahead of AW by any number of bursts
  localparam int PEND_W   = $bits(burst_cnt_t) + 1;

  logic awxfer;
  logic final_burst;
  logic no_pending;
  logic no_credit;

  assign awxfer = m_axi_awvalid && m_axi_awready;

  //////////////////////////////////////////////////////////////////////
  // Address and length
  //////////////////////////////////////////////////////////////////////

  // Only moves on an accepted address, so it holds under back-pressure
  always_ff @(posedge aclk) begin
    if (start) m_axi_awaddr <= base_addr;
    else if (awxfer) m_axi_awaddr <= m_axi_awaddr + addr_t'(BURST_BYTES);
  end

  assign m_axi_awlen = final_burst ? final_len : beat_len_t'(BURST_BEATS - 1);

  updown_counter #(
    .WIDTH ($bits(burst_cnt_t)),
    .INIT  ('0)
  ) u_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (awxfer),
    .load_value (num_bursts),
    .count      (),
    .is_zero    (final_burst)
  );

  //////////////////////////////////////////////////////////////////////
  // Issue control
  //////////////////////////////////////////////////////////////////////

  // Bursts whose first beat is on W but whose address is not yet sent
  updown_counter #(
    .WIDTH (PEND_W),
    .INIT  ('0)
  ) u_pend_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (burst_begin),
    .decr       (awxfer),
    .load_value ('0),
    .count      (),
    .is_zero    (no_pending)
  );

  // Free response slots, bready is tied high so bvalid is a response
  updown_counter #(
    .WIDTH (CREDIT_W),
    .INIT  (CREDIT_W'(MAX_OUTSTANDING))
  ) u_credit_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (m_axi_bvalid),
    .decr       (awxfer),
    .load_value ('0),
    .count      (),
    .is_zero    (no_credit)
  );

  // Drops for a cycle after each accept so the counts settle
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_awvalid <= 1'b0;
    end else if (!m_axi_awvalid && !no_pending && !no_credit) begin
      m_axi_awvalid <= 1'b1;
    end else if (m_axi_awready) begin
      m_axi_awvalid <= 1'b0;
    end
  end

endmodule

//--- rtl/wdata_channel.sv
`timescale 1ns/1ns

module wdata_channel #(
  parameter int FIFO_DEPTH = 32
) (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   start,
  input  axi_wr_pkg::burst_cnt_t num_bursts,
  input  axi_wr_pkg::beat_len_t  final_len,
  input  axi_wr_pkg::strb_t      final_strb,
  input  logic                   s_axis_tvalid,
  output logic                   s_axis_tready,
  input  axi_wr_pkg::data_t      s_axis_tdata,
  output logic                   m_axi_wvalid,
  input  logic                   m_axi_wready,
  output axi_wr_pkg::data_t      m_axi_wdata,
  output axi_wr_pkg::strb_t      m_axi_wstrb,
  output logic                   m_axi_wlast,
  output logic                   burst_begin
);
  import axi_wr_pkg::*;

  logic       running;
  logic       fifo_full;
  logic       fifo_valid;
  logic       wxfer;
  logic       load_beats;
  logic       single_burst;
  logic       final_burst;
  logic       almost_final;
  logic       final_xfer;
  burst_cnt_t bursts_left;
  logic       wfirst;
  logic       wfirst_d1;

  stream_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .aclk   (aclk),
    .areset (areset),
    .wr_en  (s_axis_tvalid),
    .din    (s_axis_tdata),
    .full   (fifo_full),
    .rd_en  (m_axi_wready && running),
    .dout   (m_axi_wdata),
    .valid  (fifo_valid)
  );

  assign s_axis_tready = !fifo_full;
  // No beats go out before the burst plan is known
  assign m_axi_wvalid  = fifo_valid && running;
  assign wxfer         = m_axi_wvalid && m_axi_wready;

  //////////////////////////////////////////////////////////////////////
  // Beat and burst counting
  //////////////////////////////////////////////////////////////////////

  assign single_burst = (num_bursts == '0);
  assign almost_final = (bursts_left == burst_cnt_t'(1));
  assign final_xfer   = wxfer && m_axi_wlast && final_burst;

  // Short last burst is loaded ahead of time, full bursts come from the wrap
  assign load_beats = (wxfer && m_axi_wlast && almost_final) || (start && single_burst);

  updown_counter #(
    .WIDTH ($bits(beat_len_t)),
    .INIT  (beat_len_t'(BURST_BEATS - 1))
  ) u_beat_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (load_beats),
    .incr       (1'b0),
    .decr       (wxfer),
    .load_value (final_len),
    .count      (),
    .is_zero    (m_axi_wlast)
  );

  updown_counter #(
    .WIDTH ($bits(burst_cnt_t)),
    .INIT  ('0)
  ) u_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (wxfer && m_axi_wlast),
    .load_value (num_bursts),
    .count      (bursts_left),
    .is_zero    (final_burst)
  );

  assign m_axi_wstrb = (m_axi_wlast && final_burst) ? final_strb : '1;

  // Running flag plus first-beat tracking
  always_ff @(posedge aclk) begin
    if (areset) begin
      running     <= 1'b0;
      wfirst      <= 1'b1;
      wfirst_d1   <= 1'b0;
      burst_begin <= 1'b0;
    end else begin
      if (start) running <= 1'b1;
      else if (final_xfer) running <= 1'b0;
      // Next beat after a wlast opens a new burst
      if (wxfer) wfirst <= m_axi_wlast;
      wfirst_d1   <= m_axi_wvalid && wfirst;
      // One pulse per burst even while the first beat is stalled
      burst_begin <= m_axi_wvalid && wfirst && !wfirst_d1;
    end
  end

endmodule

//--- rtl/stream_fifo.sv
`timescale 1ns/1ns

module stream_fifo #(
  parameter int FIFO_DEPTH = 32
) (
  input  logic              aclk,
  input  logic              areset,
  input  logic              wr_en,
  input  axi_wr_pkg::data_t din,
  output logic              full,
  input  logic              rd_en,
  output axi_wr_pkg::data_t dout,
  output logic              valid
);
  import axi_wr_pkg::*;

  localparam int PTR_W = $clog2(FIFO_DEPTH);

  data_t          mem [FIFO_DEPTH];
  // Top bit of each pointer is the wrap flag
  logic [PTR_W:0] wr_ptr;
  logic [PTR_W:0] rd_ptr;
  logic           do_write;
  logic           do_read;

  // Same slot, opposite wrap means every entry is taken
  assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                 (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
  assign valid = (wr_ptr != rd_ptr);

  // Pushes into a full buffer and pops from an empty one are dropped
  assign do_write = wr_en && !full;
  assign do_read  = rd_en && valid;

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (do_write) mem[wr_ptr[PTR_W-1:0]] <= din;
  end

  // Head entry is visible without a read request
  assign dout = mem[rd_ptr[PTR_W-1:0]];

  //////////////////////////////////////////////////////////////////////
  // Pointers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_write) wr_ptr <= wr_ptr + 1'b1;
      if (do_read) rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

//--- rtl/wr_ctrl_fsm.sv
`timescale 1ns/1ns

module wr_ctrl_fsm (
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   ctrl_start,
  input  axi_wr_pkg::addr_t      ctrl_addr_offset,
  input  axi_wr_pkg::xfer_size_t ctrl_xfer_size,
  input  logic                   m_axi_bvalid,
  output logic                   ctrl_busy,
  output logic                   ctrl_done,
  output logic                   start,
  output axi_wr_pkg::addr_t      base_addr,
  output axi_wr_pkg::burst_cnt_t num_bursts,
  output axi_wr_pkg::beat_len_t  final_len,
  output axi_wr_pkg::strb_t      final_strb
);
  import axi_wr_pkg::*;

  // Bit positions of the beat and burst fields in a byte count
  localparam int BEAT_SHIFT  = $clog2(BYTES_PER_BEAT);
  localparam int BURST_SHIFT = $clog2(BURST_BYTES);

  typedef enum logic [1:0] {idle, setup, run} state_t;

  state_t                state;
  addr_t                 offset_r;
  xfer_size_t            size_r;
  xfer_size_t            size_m1;
  logic [BEAT_SHIFT-1:0] byte_rem;
  strb_t                 strb_next;
  logic                  resp_last;

  //////////////////////////////////////////////////////////////////////
  // State machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    if (areset) begin
      state     <= idle;
      start     <= 1'b0;
      ctrl_done <= 1'b0;
    end else begin
      start     <= 1'b0;
      ctrl_done <= 1'b0;
      case (state)
        // A start pulse during a transfer never reaches here
        idle: if (ctrl_start) state <= setup;
        // Plan registers are loaded on this edge too
        setup: begin
          state <= run;
          start <= 1'b1;
        end
        run: begin
          if (m_axi_bvalid && resp_last) begin
            state     <= idle;
            ctrl_done <= 1'b1;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  assign ctrl_busy = (state != idle);

  // Request capture
  always_ff @(posedge aclk) begin
    if (state == idle && ctrl_start) begin
      offset_r <= ctrl_addr_offset;
      size_r   <= ctrl_xfer_size;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Burst plan
  //////////////////////////////////////////////////////////////////////

  // (count - 1) / 4 is the beat count minus one, rounded up
  assign size_m1  = size_r - 1'b1;
  assign byte_rem = size_r[BEAT_SHIFT-1:0];

  // Low bytes of the last beat, all of them when the count is whole beats
  always_comb begin
    strb_next = '1;
    for (int i = 0; i < BYTES_PER_BEAT; i++) begin
      if (byte_rem != '0 && i >= byte_rem) strb_next[i] = 1'b0;
    end
  end

  always_ff @(posedge aclk) begin
    if (state == setup) begin
      base_addr  <= offset_r & ~addr_t'(BURST_BYTES - 1);
      num_bursts <= size_m1[BURST_SHIFT +: $bits(burst_cnt_t)];
      final_len  <= size_m1[BEAT_SHIFT +: $bits(beat_len_t)];
      final_strb <= strb_next;
    end
  end

  // Responses still to come, minus one
  updown_counter #(
    .WIDTH ($bits(burst_cnt_t)),
    .INIT  ('0)
  ) u_resp_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (start),
    .incr       (1'b0),
    .decr       (m_axi_bvalid),
    .load_value (num_bursts),
    .count      (),
    .is_zero    (resp_last)
  );

endmodule

//--- rtl/updown_counter.sv
`timescale 1ns/1ns

module updown_counter #(
  parameter int               WIDTH = 8,
  parameter logic [WIDTH-1:0] INIT  = '0
) (
  input  logic             aclk,
  input  logic             areset,
  input  logic             load,
  input  logic             incr,
  input  logic             decr,
  input  logic [WIDTH-1:0] load_value,
  output logic [WIDTH-1:0] count,
  output logic             is_zero
);

  // Load wins over counting
  // Increment and decrement in one cycle leave the count alone
  always_ff @(posedge aclk) begin
    if (areset) begin
      count <= INIT;
    end else if (load) begin
      count <= load_value;
    end else if (incr && !decr) begin
      count <= count + 1'b1;
    end else if (decr && !incr) begin
      count <= count - 1'b1;
    end
  end

  assign is_zero = (count == '0);

endmodule

//--- rtl/axi_wr_pkg.sv
package axi_wr_pkg;

  ////////////////////////////////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////////////////////////////////

  // AXI4 address and data widths
  parameter int ADDR_W = 32;
  parameter int DATA_W = 32;
  // Byte lanes in one data beat
  parameter int BYTES_PER_BEAT = DATA_W / 8;
  // Width of the transfer byte count
  parameter int XFER_W = 24;

  ////////////////////////////////////////////////////////////////////
  // Burst constants
  ////////////////////////////////////////////////////////////////////

  // AXI4 protocol limits for an INCR burst
  parameter int AXI_MAX_BURST_BYTES = 4096;
  parameter int AXI_MAX_BURST_LEN   = 256;
  // Full burst, the smaller of the two limits
  parameter int BURST_BEATS = (AXI_MAX_BURST_BYTES / BYTES_PER_BEAT < AXI_MAX_BURST_LEN) ?
                              AXI_MAX_BURST_BYTES / BYTES_PER_BEAT : AXI_MAX_BURST_LEN;
  // Address step between bursts, also the start alignment
  parameter int BURST_BYTES = BURST_BEATS * BYTES_PER_BEAT;

  // Vector types
  typedef logic [ADDR_W-1:0]         addr_t;
  typedef logic [DATA_W-1:0]         data_t;
  typedef logic [BYTES_PER_BEAT-1:0] strb_t;
  typedef logic [XFER_W-1:0]         xfer_size_t;
  // Burst length minus one, awlen format
  typedef logic [$clog2(BURST_BEATS)-1:0] beat_len_t;
  // Number of bursts minus one
  typedef logic [XFER_W-$clog2(BYTES_PER_BEAT)-$clog2(BURST_BEATS)-1:0] burst_cnt_t;

endpackage
